/* Bender.yml */
package:
  name: micro_cpu

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/cpuAlu.sv
      - hw/busPort.sv
      - hw/dataRegs.sv
      - hw/programCounter.sv
      - hw/cpuControl.sv
      - hw/microCpu.sv
  - target: test
    files:
      - verification/cpuMemModel.sv
      - verification/microCpuTb.sv

/* all.f */
hw/cpuPkg.sv
hw/cpuAlu.sv
hw/busPort.sv
hw/dataRegs.sv
hw/programCounter.sv
hw/cpuControl.sv
hw/microCpu.sv
verification/cpuMemModel.sv
verification/microCpuTb.sv

/* hw/busPort.sv */
module busPort #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  cpuPkg::busCmd_t       busCmd,
    input  logic                  regSelect,
    input  logic [DataWidth-1:0]  romData,
    input  logic [DataWidth-1:0]  regA,
    input  logic [DataWidth-1:0]  regB,
    output logic [DataWidth-1:0]  busAddr,
    output logic [DataWidth-1:0]  busDataOut,
    output logic                  busWe
);

    logic [DataWidth-1:0] selReg;

    // Pointer for a dereference, or the value to store
    assign selReg = regSelect ? regB : regA;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= DataWidth'(cpuPkg::BusIdleAddr);
            busWe   <= 1'b0;
        end else begin
            // Strobe lasts one cycle per write command
            busWe <= (busCmd == cpuPkg::BusWrite);
            case (busCmd)
                cpuPkg::BusReadRom, cpuPkg::BusWrite: busAddr <= romData;
                cpuPkg::BusReadReg:                   busAddr <= selReg;
                default: busAddr <= DataWidth'(cpuPkg::BusIdleAddr);
            endcase
        end
    end

    // Write data lines up with the strobe
    always_ff @(posedge CLK) begin
        if (busCmd == cpuPkg::BusWrite) begin
            busDataOut <= selReg;
        end
    end

endmodule

/* hw/cpuAlu.sv */
module cpuAlu #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [DataWidth-1:0]  opA,
    input  logic [DataWidth-1:0]  opB,
    input  logic [DataWidth-1:0]  romData,
    output logic [DataWidth-1:0]  aluResult
);

    cpuPkg::aluOp_t aluOp;

    // Operation rides in the high nibble of the opcode byte
    assign aluOp = cpuPkg::aluOp_t'(romData[7:4]);

    // Sampled every clock, result is used one cycle later
    always_ff @(posedge CLK) begin
        if (RESET) begin
            aluResult <= '0;
        end else begin
            case (aluOp)
                cpuPkg::AluAdd:  aluResult <= opA + opB;
                cpuPkg::AluSub:  aluResult <= opA - opB;
                // Low half of the product
                cpuPkg::AluMul:  aluResult <= opA * opB;
                cpuPkg::AluShl:  aluResult <= opA << 1;
                cpuPkg::AluShr:  aluResult <= opA >> 1;
                cpuPkg::AluIncA: aluResult <= opA + DataWidth'(1);
                cpuPkg::AluIncB: aluResult <= opB + DataWidth'(1);
                cpuPkg::AluDecA: aluResult <= opA - DataWidth'(1);
                cpuPkg::AluDecB: aluResult <= opB - DataWidth'(1);
                // Comparisons give 1 or 0 for the branch test
                cpuPkg::AluEq:   aluResult <= DataWidth'(opA == opB);
                cpuPkg::AluGt:   aluResult <= DataWidth'(opA > opB);
                cpuPkg::AluLt:   aluResult <= DataWidth'(opA < opB);
                default:         aluResult <= opA;
            endcase
        end
    end

endmodule

/* hw/cpuControl.sv */
module cpuControl #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [DataWidth-1:0]  romData,
    input  logic [DataWidth-1:0]  aluResult,
    input  logic [1:0]            irqRaise,
    output cpuPkg::pcCmd_t        pcCmd,
    output logic                  saveContext,
    output logic                  offsetNext,
    output logic                  regLoadA,
    output logic                  regLoadB,
    output cpuPkg::regSrc_t       regSource,
    output cpuPkg::busCmd_t       busCmd,
    output logic                  regSelect,
    output logic [1:0]            irqAck
);

    cpuPkg::cpuState_t state;
    cpuPkg::cpuState_t stateNext;
    // Remembered register choice where 0 means A and 1 means B
    logic              regSelQ;
    logic              regSelNext;
    logic [1:0]        ackNext;

    // Bus port sees the choice made in this cycle
    assign regSelect = regSelNext;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= cpuPkg::StChooseOp;
            regSelQ <= 1'b0;
            irqAck  <= 2'b00;
        end else begin
            state   <= stateNext;
            regSelQ <= regSelNext;
            irqAck  <= ackNext;
        end
    end

    always_comb begin
        // Default is to hold everything and park the bus
        stateNext   = state;
        pcCmd       = cpuPkg::PcHold;
        saveContext = 1'b0;
        offsetNext  = cpuPkg::OffsetNone;
        regLoadA    = 1'b0;
        regLoadB    = 1'b0;
        regSource   = cpuPkg::RegSrcBus;
        busCmd      = cpuPkg::BusIdle;
        regSelNext  = regSelQ;
        ackNext     = 2'b00;

        case (state)
            ////////////////////
            // Thread start
            cpuPkg::StIdle: begin
                // Line 0 wins when both are raised
                if (irqRaise[0]) begin
                    stateNext = cpuPkg::StStart0;
                    pcCmd     = cpuPkg::PcLoadVecA;
                    ackNext   = 2'b01;
                end else if (irqRaise[1]) begin
                    stateNext = cpuPkg::StStart0;
                    pcCmd     = cpuPkg::PcLoadVecB;
                    ackNext   = 2'b10;
                end
            end
            cpuPkg::StStart0: stateNext = cpuPkg::StStart1;
            cpuPkg::StStart1: begin
                // ROM now shows the vector word
                stateNext = cpuPkg::StStart2;
                pcCmd     = cpuPkg::PcLoadRom;
            end
            cpuPkg::StStart2: stateNext = cpuPkg::StChooseOp;

            ////////////////////
            // Decode
            cpuPkg::StChooseOp: begin
                // Operand byte is fetched next cycle
                offsetNext = cpuPkg::OffsetNext;
                case (cpuPkg::opCode_t'(romData[3:0]))
                    cpuPkg::OpReadA:  stateNext = cpuPkg::StReadToA;
                    cpuPkg::OpReadB:  stateNext = cpuPkg::StReadToB;
                    cpuPkg::OpWriteA: stateNext = cpuPkg::StWriteA;
                    cpuPkg::OpWriteB: stateNext = cpuPkg::StWriteB;
                    cpuPkg::OpMathsA: stateNext = cpuPkg::StMathsToA;
                    cpuPkg::OpMathsB: stateNext = cpuPkg::StMathsToB;
                    cpuPkg::OpBranch: stateNext = cpuPkg::StBranch;
                    cpuPkg::OpGoto:   stateNext = cpuPkg::StGoto;
                    cpuPkg::OpCall:   stateNext = cpuPkg::StCall;
                    cpuPkg::OpReturn: stateNext = cpuPkg::StReturn;
                    cpuPkg::OpDerefA: stateNext = cpuPkg::StDerefA;
                    cpuPkg::OpDerefB: stateNext = cpuPkg::StDerefB;
                    // Idle opcode and unknown codes end the thread
                    default:          stateNext = cpuPkg::StIdle;
                endcase
            end

            ////////////////////
            // Memory access
            cpuPkg::StReadToA, cpuPkg::StReadToB: begin
                stateNext  = cpuPkg::StRead0;
                regSelNext = (state == cpuPkg::StReadToB);
                // Keep the operand on the ROM for one more cycle
                offsetNext = cpuPkg::OffsetNext;
            end
            cpuPkg::StRead0: begin
                stateNext = cpuPkg::StRead1;
                busCmd    = cpuPkg::BusReadRom;
            end
            cpuPkg::StRead1: begin
                // Address is on the bus so the data is valid now
                stateNext = cpuPkg::StRead2;
                regLoadA  = !regSelQ;
                regLoadB  = regSelQ;
                pcCmd     = cpuPkg::PcInc2;
            end
            cpuPkg::StRead2: stateNext = cpuPkg::StChooseOp;
            cpuPkg::StWriteA, cpuPkg::StWriteB: begin
                // Operand is the target address
                stateNext  = cpuPkg::StWrite0;
                regSelNext = (state == cpuPkg::StWriteB);
                busCmd     = cpuPkg::BusWrite;
                pcCmd      = cpuPkg::PcInc2;
            end
            cpuPkg::StWrite0: stateNext = cpuPkg::StChooseOp;

            ////////////////////
            // ALU and flow control
            cpuPkg::StMathsToA, cpuPkg::StMathsToB: begin
                // Result sampled during decode is ready
                stateNext = cpuPkg::StMaths0;
                regSource = cpuPkg::RegSrcAlu;
                regLoadA  = (state == cpuPkg::StMathsToA);
                regLoadB  = (state == cpuPkg::StMathsToB);
                pcCmd     = cpuPkg::PcInc1;
            end
            cpuPkg::StMaths0: stateNext = cpuPkg::StChooseOp;
            cpuPkg::StBranch: begin
                if (aluResult != '0) begin
                    stateNext  = cpuPkg::StBranch0;
                    offsetNext = cpuPkg::OffsetNext;
                end else begin
                    stateNext = cpuPkg::StBranch1;
                    pcCmd     = cpuPkg::PcInc2;
                end
            end
            cpuPkg::StBranch0: begin
                stateNext = cpuPkg::StBranch1;
                pcCmd     = cpuPkg::PcLoadRom;
            end
            cpuPkg::StBranch1: stateNext = cpuPkg::StChooseOp;
            cpuPkg::StGoto: begin
                stateNext  = cpuPkg::StGoto0;
                offsetNext = cpuPkg::OffsetNext;
            end
            cpuPkg::StGoto0: begin
                stateNext = cpuPkg::StGoto1;
                pcCmd     = cpuPkg::PcLoadRom;
            end
            cpuPkg::StGoto1: stateNext = cpuPkg::StChooseOp;
            cpuPkg::StCall: begin
                // Return lands after the two-byte call
                stateNext   = cpuPkg::StCall0;
                saveContext = 1'b1;
                offsetNext  = cpuPkg::OffsetNext;
            end
            cpuPkg::StCall0: begin
                stateNext = cpuPkg::StCall1;
                pcCmd     = cpuPkg::PcLoadRom;
            end
            cpuPkg::StCall1: stateNext = cpuPkg::StChooseOp;
            cpuPkg::StReturn: begin
                stateNext = cpuPkg::StReturn0;
                pcCmd     = cpuPkg::PcLoadCtx;
            end
            cpuPkg::StReturn0: stateNext = cpuPkg::StChooseOp;

            ////////////////////
            // Dereference
            cpuPkg::StDerefA, cpuPkg::StDerefB: begin
                // Register value is the pointer
                stateNext  = cpuPkg::StDeref0;
                regSelNext = (state == cpuPkg::StDerefB);
                busCmd     = cpuPkg::BusReadReg;
            end
            cpuPkg::StDeref0: begin
                stateNext = cpuPkg::StDeref1;
                regLoadA  = !regSelQ;
                regLoadB  = regSelQ;
                pcCmd     = cpuPkg::PcInc1;
            end
            cpuPkg::StDeref1: stateNext = cpuPkg::StChooseOp;

            default: stateNext = cpuPkg::StIdle;
        endcase
    end

    // Single-cycle one-hot acknowledge for a line raised in the cycle before
    // Line 1 is answered only while line 0 is quiet
    ackPulse: assert property (@(posedge CLK) disable iff (RESET)
        (irqAck != 2'b00) |->
            ($onehot(irqAck) &&
             ((irqAck == 2'b01) ? $past(irqRaise[0]) : ($past(irqRaise) == 2'b10)))
            ##1 (irqAck == 2'b00));

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

    // Width of data words, bus addresses and registers A and B
    parameter int DataWidth = 8;

    ////////////////////
    // Instruction set

    // Instruction class, low nibble of the opcode byte
    typedef enum logic [3:0] {
        OpReadA   = 4'h0, OpReadB   = 4'h1,
        OpWriteA  = 4'h2, OpWriteB  = 4'h3,
        OpMathsA  = 4'h4, OpMathsB  = 4'h5,
        OpBranch  = 4'h6, OpGoto    = 4'h7,
        OpIdle    = 4'h8, OpCall    = 4'h9,
        OpReturn  = 4'hA, OpDerefA  = 4'hB,
        OpDerefB  = 4'hC
    } opCode_t;

    // ALU operation, high nibble of the opcode byte
    // Codes outside this list pass A through
    typedef enum logic [3:0] {
        AluAdd  = 4'h0, AluSub  = 4'h1, AluMul  = 4'h2,
        AluShl  = 4'h3, AluShr  = 4'h4,
        AluIncA = 4'h5, AluIncB = 4'h6,
        AluDecA = 4'h7, AluDecB = 4'h8,
        AluEq   = 4'h9, AluGt   = 4'hA, AluLt   = 4'hB
    } aluOp_t;

    ////////////////////
    // Controller states

    // Upper nibble groups the states of one operation
    typedef enum logic [7:0] {
        StIdle      = 8'hF0, StStart0    = 8'hF1, StStart1 = 8'hF2, StStart2 = 8'hF3,
        StChooseOp  = 8'h00,
        StReadToA   = 8'h10, StReadToB   = 8'h11,
        StRead0     = 8'h12, StRead1     = 8'h13, StRead2  = 8'h14,
        StWriteA    = 8'h20, StWriteB    = 8'h21, StWrite0 = 8'h22,
        StMathsToA  = 8'h30, StMathsToB  = 8'h31, StMaths0 = 8'h32,
        StBranch    = 8'h40, StBranch0   = 8'h41, StBranch1 = 8'h42,
        StGoto      = 8'h50, StGoto0     = 8'h51, StGoto1  = 8'h52,
        StCall      = 8'h60, StCall0     = 8'h61, StCall1  = 8'h62,
        StReturn    = 8'h70, StReturn0   = 8'h71,
        StDerefA    = 8'h80, StDerefB    = 8'h81,
        StDeref0    = 8'h82, StDeref1    = 8'h83
    } cpuState_t;

    ////////////////////
    // Datapath commands

    // Program counter update for the next cycle
    typedef enum logic [2:0] {
        PcHold, PcInc1, PcInc2, PcLoadRom, PcLoadCtx, PcLoadVecA, PcLoadVecB
    } pcCmd_t;

    // Load source of registers A and B
    typedef enum logic [1:0] {
        RegSrcRom, RegSrcBus, RegSrcAlu
    } regSrc_t;

    // Bus port command, registered on the next edge
    typedef enum logic [1:0] {
        BusIdle, BusReadRom, BusReadReg, BusWrite
    } busCmd_t;

    // ROM words holding the thread start addresses
    parameter logic [7:0] IrqVectorA = 8'hFF;
    parameter logic [7:0] IrqVectorB = 8'hFE;

    // Address parked on the bus between accesses
    parameter logic [7:0] BusIdleAddr = 8'hFF;

    // Fetch offset, opcode byte or the operand after it
    parameter logic OffsetNone = 1'b0;
    parameter logic OffsetNext = 1'b1;

endpackage

/* hw/dataRegs.sv */
module dataRegs #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  regLoadA,
    input  logic                  regLoadB,
    input  cpuPkg::regSrc_t       regSource,
    input  logic [DataWidth-1:0]  romData,
    input  logic [DataWidth-1:0]  busDataIn,
    input  logic [DataWidth-1:0]  aluResult,
    output logic [DataWidth-1:0]  regA,
    output logic [DataWidth-1:0]  regB
);

    logic [DataWidth-1:0] loadValue;

    // One shared source for whichever register loads
    always_comb begin
        case (regSource)
            cpuPkg::RegSrcRom: loadValue = romData;
            cpuPkg::RegSrcBus: loadValue = busDataIn;
            default:           loadValue = aluResult;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            if (regLoadA) begin
                regA <= loadValue;
            end
            if (regLoadB) begin
                regB <= loadValue;
            end
        end
    end

    // Controller picks exactly one destination per load
    oneDest: assert property (@(posedge CLK) disable iff (RESET)
        !(regLoadA && regLoadB));

endmodule

/* hw/microCpu.sv */
module microCpu #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    output logic [DataWidth-1:0]  romAddr,
    input  logic [DataWidth-1:0]  romData,
    output logic [DataWidth-1:0]  busAddr,
    output logic [DataWidth-1:0]  busDataOut,
    output logic                  busWe,
    input  logic [DataWidth-1:0]  busDataIn,
    input  logic [1:0]            irqRaise,
    output logic [1:0]            irqAck
);

    ////////////////////
    // Control to datapath
    cpuPkg::pcCmd_t       pcCmd;
    logic                 saveContext;
    logic                 offsetNext;
    logic                 regLoadA;
    logic                 regLoadB;
    cpuPkg::regSrc_t      regSource;
    cpuPkg::busCmd_t      busCmd;
    logic                 regSelect;

    ////////////////////
    // Datapath values
    logic [DataWidth-1:0] regA;
    logic [DataWidth-1:0] regB;
    logic [DataWidth-1:0] aluResult;

    cpuControl #(.DataWidth(DataWidth)) i_cpuControl (
        .CLK(CLK), .RESET(RESET), .romData(romData), .aluResult(aluResult),
        .irqRaise(irqRaise), .pcCmd(pcCmd), .saveContext(saveContext),
        .offsetNext(offsetNext), .regLoadA(regLoadA), .regLoadB(regLoadB),
        .regSource(regSource), .busCmd(busCmd), .regSelect(regSelect), .irqAck(irqAck)
    );

    programCounter #(.DataWidth(DataWidth)) i_programCounter (
        .CLK(CLK), .RESET(RESET), .pcCmd(pcCmd), .saveContext(saveContext),
        .offsetNext(offsetNext), .romData(romData), .romAddr(romAddr)
    );

    dataRegs #(.DataWidth(DataWidth)) i_dataRegs (
        .CLK(CLK), .RESET(RESET), .regLoadA(regLoadA), .regLoadB(regLoadB),
        .regSource(regSource), .romData(romData), .busDataIn(busDataIn),
        .aluResult(aluResult), .regA(regA), .regB(regB)
    );

    // ALU reads the opcode byte straight from the ROM
    cpuAlu #(.DataWidth(DataWidth)) i_cpuAlu (
        .CLK(CLK), .RESET(RESET), .opA(regA), .opB(regB), .romData(romData),
        .aluResult(aluResult)
    );

    busPort #(.DataWidth(DataWidth)) i_busPort (
        .CLK(CLK), .RESET(RESET), .busCmd(busCmd), .regSelect(regSelect),
        .romData(romData), .regA(regA), .regB(regB), .busAddr(busAddr),
        .busDataOut(busDataOut), .busWe(busWe)
    );

endmodule

/* hw/programCounter.sv */
module programCounter #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  cpuPkg::pcCmd_t        pcCmd,
    input  logic                  saveContext,
    input  logic                  offsetNext,
    input  logic [DataWidth-1:0]  romData,
    output logic [DataWidth-1:0]  romAddr
);

    logic [DataWidth-1:0] pc;
    // Address saved by a call
    logic [DataWidth-1:0] returnAddr;
    // Selects the opcode byte or its operand
    logic                 offset;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc         <= '0;
            offset     <= cpuPkg::OffsetNone;
            returnAddr <= '0;
        end else begin
            offset <= offsetNext;
            case (pcCmd)
                cpuPkg::PcInc1:     pc <= pc + DataWidth'(1);
                cpuPkg::PcInc2:     pc <= pc + DataWidth'(2);
                cpuPkg::PcLoadRom:  pc <= romData;
                cpuPkg::PcLoadCtx:  pc <= returnAddr;
                cpuPkg::PcLoadVecA: pc <= DataWidth'(cpuPkg::IrqVectorA);
                cpuPkg::PcLoadVecB: pc <= DataWidth'(cpuPkg::IrqVectorB);
                default:            pc <= pc;
            endcase
            // Skip the call opcode and its target byte
            if (saveContext) begin
                returnAddr <= pc + DataWidth'(2);
            end
        end
    end

    // Combinational ROM answers in the same cycle
    assign romAddr = pc + DataWidth'(offset);

    // Return and call sequences never overlap
    ctxExclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(pcCmd == cpuPkg::PcLoadCtx && saveContext));

endmodule

/* verification/cpuMemModel.sv */
module cpuMemModel #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [DataWidth-1:0]  romAddr,
    output logic [DataWidth-1:0]  romData,
    input  logic [DataWidth-1:0]  busAddr,
    input  logic [DataWidth-1:0]  busDataOut,
    input  logic                  busWe,
    output logic [DataWidth-1:0]  busDataIn
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int Depth = 2 ** DataWidth;

    // Program ROM and data memory, loaded by the testbench
    logic [DataWidth-1:0] rom [Depth];
    logic [DataWidth-1:0] mem [Depth];

    // Bus writes in the order they happened
    logic [DataWidth-1:0] writeAddr [$];
    logic [DataWidth-1:0] writeData [$];

    // Both memories answer in the same cycle
    assign romData   = rom[romAddr];
    assign busDataIn = mem[busAddr];

    ////////////////////
    // Write strobe

    always @(posedge CLK) begin
        if (!RESET && busWe) begin
            mem[busAddr] <= busDataOut;
            writeAddr.push_back(busAddr);
            writeData.push_back(busDataOut);
        end
    end

    ////////////////////
    // Contents between tests

    task automatic resetContents();
        for (int a = 0; a < Depth; a++) begin
            // Idle opcode everywhere, ALU nibble varies with the address
            rom[a] = DataWidth'(((((a >> 4) ^ a) & 'hF) << 4) | 'h8);
            mem[a] = DataWidth'(a ^ 'h5A);
        end
        writeAddr.delete();
        writeData.delete();
    endtask

endmodule

/* verification/cpuStimulus.txt */
# Records: test name | rom or mem: start hex, count decimal, bytes hex | irq: lines hex
# expect: count decimal, then address and data pairs in hex in write order
test readMathsWrite
rom 00 1 08
rom FE 2 20 10
rom 10 17 00 40 01 41 04 02 80 14 02 81 24 02 82 15 03 83 08
mem 40 2 17 05
irq 1
expect 4 80 1C 81 17 82 73 83 6E
test shiftIncDec
rom 00 1 08
rom FE 2 20 10
rom 10 23 00 40 01 41 34 02 80 44 02 81 65 03 82 85 03 83 74 02 84 55 03 85 08
mem 40 2 81 FF
irq 1
expect 6 80 02 81 01 82 00 83 FF 84 00 85 01
test branches
rom 00 1 08
rom FE 2 20 10
rom 10 29 00 40 01 41 96 30 A6 30 B6 1C 02 90 03 91 07 22 02 92 02 93 01 40 96 2A 02 94 02 95 08
rom 30 3 02 9F 08
mem 40 2 05 09
irq 1
expect 3 91 09 93 05 95 05
test callReturn
rom 00 1 08
rom FE 2 20 10
rom 10 7 00 40 09 30 03 A1 08
rom 30 4 55 02 A0 0A
mem 40 1 33
irq 1
expect 2 A0 33 A1 34
test derefIdle
rom 00 1 08
rom FE 2 20 10
rom 10 3 02 EE 08
rom 20 13 00 40 0B 02 B0 01 41 0C 03 B1 08 02 BF
mem 40 2 50 60
mem 50 1 C3
mem 60 1 3C
irq 2
expect 2 B0 C3 B1 3C
test bothLines
rom 00 1 08
rom FE 2 20 10
rom 10 5 00 40 02 C0 08
rom 20 5 01 41 03 C1 08
mem 40 2 11 22
irq 3
expect 2 C0 11 C1 22

/* verification/microCpuTb.sv */
module microCpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DataWidth   = cpuPkg::DataWidth;
    localparam int ClkPeriod   = 10;
    // Watchdog budget per test
    localparam int TestCycles  = 200;
    // Per test wait, leaves room for reset and the quiet window
    localparam int WaitCycles  = 150;
    localparam int QuietCycles = 10;
    localparam     StimPath    = "verification/cpuStimulus.txt";

    logic                 CLK;
    logic                 RESET;
    logic [DataWidth-1:0] romAddr;
    logic [DataWidth-1:0] romData;
    logic [DataWidth-1:0] busAddr;
    logic [DataWidth-1:0] busDataOut;
    logic                 busWe;
    logic [DataWidth-1:0] busDataIn;
    logic [1:0]           irqRaise;
    logic [1:0]           irqAck;

    // Current test and its expected writes
    string                testName;
    logic [1:0]           irqReq;
    logic [DataWidth-1:0] expAddr [$];
    logic [DataWidth-1:0] expData [$];
    // Acknowledges seen during the current test
    logic [1:0]           ackLog [$];

    int numTests    = 0;
    int testsRun    = 0;
    int testsFailed = 0;
    int errorCount  = 0;
    int testErrors  = 0;

    microCpu #(.DataWidth(DataWidth)) i_microCpu (
        .CLK(CLK), .RESET(RESET), .romAddr(romAddr), .romData(romData),
        .busAddr(busAddr), .busDataOut(busDataOut), .busWe(busWe),
        .busDataIn(busDataIn), .irqRaise(irqRaise), .irqAck(irqAck)
    );

    cpuMemModel #(.DataWidth(DataWidth)) i_cpuMemModel (
        .CLK(CLK), .RESET(RESET), .romAddr(romAddr), .romData(romData),
        .busAddr(busAddr), .busDataOut(busDataOut), .busWe(busWe),
        .busDataIn(busDataIn)
    );

    always #(ClkPeriod / 2) CLK = ~CLK;

    // Record each acknowledge and drop the request it answers
    always @(posedge CLK) begin
        if (!RESET && irqAck != 2'b00) begin
            ackLog.push_back(irqAck);
            irqRaise <= irqRaise & ~irqAck;
        end
    end

    ////////////////////
    // Checks

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s %s expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    ////////////////////
    // Stimulus file

    // Next keyword, comment lines skipped
    task automatic readKeyword(input int fd, output string kw, output bit found);
        logic [8*256-1:0] rest;
        int               code;
        code = $fscanf(fd, "%s", kw);
        while (code == 1 && kw.substr(0, 0) == "#") begin
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", kw);
        end
        found = (code == 1);
    endtask

    task automatic countTests();
        int               fd;
        int               code;
        string            kw;
        bit               found;
        logic [8*256-1:0] rest;
        fd = $fopen(StimPath, "r");
        if (fd != 0) begin
            readKeyword(fd, kw, found);
            while (found) begin
                if (kw == "test") begin
                    numTests++;
                end
                code = $fgets(rest, fd);
                readKeyword(fd, kw, found);
            end
            $fclose(fd);
        end
    endtask

    // Start address, byte count, then the bytes
    task automatic loadBytes(input int fd, input bit toRom);
        int addr;
        int count;
        int value;
        int code;
        int i;
        code = $fscanf(fd, "%h", addr);
        code = $fscanf(fd, "%d", count);
        for (i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", value);
            if (toRom) begin
                i_cpuMemModel.rom[(addr + i) % (2 ** DataWidth)] = value[DataWidth-1:0];
            end else begin
                i_cpuMemModel.mem[(addr + i) % (2 ** DataWidth)] = value[DataWidth-1:0];
            end
        end
    endtask

    // Write count, then address and data pairs
    task automatic readExpected(input int fd);
        int count;
        int addr;
        int data;
        int code;
        int i;
        code = $fscanf(fd, "%d", count);
        expAddr.delete();
        expData.delete();
        for (i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", addr);
            code = $fscanf(fd, "%h", data);
            expAddr.push_back(addr[DataWidth-1:0]);
            expData.push_back(data[DataWidth-1:0]);
        end
    endtask

    ////////////////////
    // One test

    task automatic runTest();
        logic [1:0] expAck [$];
        int         waited;
        int         i;
        // Line 0 is served first when both are raised
        if (irqReq[0]) begin
            expAck.push_back(2'b01);
        end
        if (irqReq[1]) begin
            expAck.push_back(2'b10);
        end
        repeat (3) @(posedge CLK);
        RESET    <= 1'b0;
        irqRaise <= irqReq;
        @(negedge CLK);
        // State right after reset
        checkValue("reset romAddr", 0, romAddr);
        checkValue("reset busAddr", cpuPkg::BusIdleAddr, busAddr);
        checkValue("reset busWe", 0, busWe);
        checkValue("reset irqAck", 0, irqAck);
        waited = 0;
        while ((i_cpuMemModel.writeAddr.size() < expAddr.size() ||
                ackLog.size() < expAck.size()) && waited < WaitCycles) begin
            @(negedge CLK);
            waited++;
        end
        if (i_cpuMemModel.writeAddr.size() < expAddr.size() ||
            ackLog.size() < expAck.size()) begin
            $display("Test %s timed out waiting for its bus writes", testName);
            errorCount++;
            testErrors++;
        end
        // Catch stray writes after the last expected one
        repeat (QuietCycles) @(negedge CLK);
        checkValue("write count", expAddr.size(), i_cpuMemModel.writeAddr.size());
        for (i = 0; i < expAddr.size(); i++) begin
            if (i < i_cpuMemModel.writeAddr.size()) begin
                checkValue($sformatf("write %0d address", i), expAddr[i],
                           i_cpuMemModel.writeAddr[i]);
                checkValue($sformatf("write %0d data", i), expData[i],
                           i_cpuMemModel.writeData[i]);
            end
        end
        checkValue("ack count", expAck.size(), ackLog.size());
        for (i = 0; i < expAck.size(); i++) begin
            if (i < ackLog.size()) begin
                checkValue($sformatf("ack %0d", i), expAck[i], ackLog[i]);
            end
        end
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %s passed", testName);
        end else begin
            $display("Test %s failed with %0d errors", testName, testErrors);
            testsFailed++;
        end
        // Hold the processor in reset while the next test loads
        @(posedge CLK);
        RESET    <= 1'b1;
        irqRaise <= 2'b00;
    endtask

    ////////////////////
    // Main sequence

    initial begin
        int    fd;
        int    code;
        string kw;
        bit    found;
        CLK      = 1'b0;
        RESET    = 1'b1;
        irqRaise = 2'b00;
        irqReq   = 2'b00;
        countTests();
        fd = $fopen(StimPath, "r");
        if (fd != 0) begin
            readKeyword(fd, kw, found);
            while (found) begin
                if (kw == "test") begin
                    code = $fscanf(fd, "%s", testName);
                    i_cpuMemModel.resetContents();
                    ackLog.delete();
                    irqReq     = 2'b00;
                    testErrors = 0;
                end else if (kw == "rom") begin
                    loadBytes(fd, 1'b1);
                end else if (kw == "mem") begin
                    loadBytes(fd, 1'b0);
                end else if (kw == "irq") begin
                    code = $fscanf(fd, "%h", irqReq);
                end else if (kw == "expect") begin
                    // Last record of a test starts it
                    readExpected(fd);
                    runTest();
                end else begin
                    $display("Unknown record %s in the stimulus file", kw);
                    errorCount++;
                end
                readKeyword(fd, kw, found);
            end
            $fclose(fd);
        end else begin
            $display("Cannot open the stimulus file %s", StimPath);
            errorCount++;
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (testsRun > 0 && testsFailed == 0 && errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Ends a hung run, budget scales with the number of tests
    initial begin
        wait (numTests > 0);
        #(numTests * TestCycles * ClkPeriod);
        $display("Watchdog expired, the run hung");
        $display("** FAIL **");
        $finish;
    end

endmodule
